//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int data_bits      = 32;
  localparam int regno_bits     = 4;   // sixteen registers
  localparam int imm_bits       = 16;
  localparam int imem_addr_bits = 12;  // word index of 4096 words
  localparam int dmem_addr_bits = 12;
  localparam int led_bits       = 10;
  localparam int hex_bits       = 24;

  // --------------------------------------------------
  // addresses and constants
  // --------------------------------------------------
  localparam logic [data_bits-1:0] start_pc  = 32'h0000_0100;
  localparam logic [data_bits-1:0] inst_size = 32'd4;
  localparam logic [data_bits-1:0] addr_hex  = 32'hFFFF_F000;
  localparam logic [data_bits-1:0] addr_ledr = 32'hFFFF_F020;

  localparam logic [hex_bits-1:0] hex_reset_value = 24'hFEDEAD;

  // instruction fields
  localparam int op1_msb = 31;
  localparam int op1_lsb = 26;
  localparam int op2_msb = 25;
  localparam int op2_lsb = 18;
  localparam int imm_msb = 23;  // overlaps op2 and rd
  localparam int imm_lsb = 8;
  localparam int rd_msb  = 11;
  localparam int rd_lsb  = 8;
  localparam int rs_msb  = 7;
  localparam int rs_lsb  = 4;
  localparam int rt_msb  = 3;
  localparam int rt_lsb  = 0;

  // primary opcode
  typedef enum logic [5:0] {
    op1_alur = 6'b000000,
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_ble  = 6'b001010,
    op1_bne  = 6'b001011,
    op1_jal  = 6'b001100,
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } op1_t;

  // alu function used only with op1_alur
  typedef enum logic [7:0] {
    op2_eq   = 8'b00001000,
    op2_lt   = 8'b00001001,
    op2_le   = 8'b00001010,
    op2_ne   = 8'b00001011,
    op2_add  = 8'b00100000,
    op2_and  = 8'b00100100,
    op2_or   = 8'b00100101,
    op2_xor  = 8'b00100110,
    op2_sub  = 8'b00101000,
    op2_nand = 8'b00101100,
    op2_nor  = 8'b00101101,
    op2_nxor = 8'b00101110,
    op2_rshf = 8'b00110000,
    op2_lshf = 8'b00110001
  } op2_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               stall,
  input  wire logic                               redirect,
  input  wire logic [cpu_pkg::data_bits-1:0]      redirect_pc,
  input  wire logic                               imem_we,
  input  wire logic [cpu_pkg::imem_addr_bits-1:0] imem_addr,
  input  wire logic [cpu_pkg::data_bits-1:0]      imem_data,
  output logic      [cpu_pkg::data_bits-1:0]      fetch_inst,
  output logic      [cpu_pkg::data_bits-1:0]      fetch_pc_next
);

  import cpu_pkg::*;

  logic [data_bits-1:0] pc;
  logic [data_bits-1:0] pc_plus;
  logic [data_bits-1:0] inst_now;
  logic [data_bits-1:0] imem [0:(1 << imem_addr_bits)-1];

  // load port filled by the boot loader while reset is held
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  assign inst_now = imem[pc[imem_addr_bits+1:2]];  // word addressed
  assign pc_plus  = pc + inst_size;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= start_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc_plus;
    end
  end

  // --------------------------------------------------
  // fetch latch
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch_inst <= '0;
    end else if (redirect) begin
      fetch_inst <= '0;  // all zero word is a bubble
    end else if (!stall) begin
      fetch_inst <= inst_now;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fetch_pc_next <= pc_plus;
    end
  end

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`default_nettype none

module decode_unit (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic [cpu_pkg::data_bits-1:0]  fetch_inst,
  input  wire logic [cpu_pkg::data_bits-1:0]  fetch_pc_next,
  input  wire logic                           redirect,
  input  wire logic [cpu_pkg::data_bits-1:0]  alu_now,
  input  wire logic [cpu_pkg::regno_bits-1:0] ex_wregno,
  input  wire logic                           ex_wr_reg,
  input  wire logic [cpu_pkg::data_bits-1:0]  mem_result,
  input  wire logic [cpu_pkg::data_bits-1:0]  wb_val,
  input  wire logic [cpu_pkg::regno_bits-1:0] wb_wregno,
  input  wire logic                           wb_wr_reg,
  output logic                                stall,
  output logic                                dec_valid,
  output cpu_pkg::op1_t                       dec_op1,
  output cpu_pkg::op2_t                       dec_op2,
  output logic      [cpu_pkg::data_bits-1:0]  dec_val1,
  output logic      [cpu_pkg::data_bits-1:0]  dec_val2,
  output logic      [cpu_pkg::data_bits-1:0]  dec_imm,
  output logic      [cpu_pkg::data_bits-1:0]  dec_pc_next,
  output logic      [cpu_pkg::regno_bits-1:0] dec_wregno,
  output logic                                dec_wr_reg,
  output logic                                dec_rd_mem,
  output logic                                dec_wr_mem
);

  import cpu_pkg::*;

  op1_t                  op1;
  op2_t                  op2;
  logic [imm_bits-1:0]   imm;
  logic [data_bits-1:0]  imm_sx;
  logic [regno_bits-1:0] rd, rs, rt, wregno;
  logic                  wr_reg, rd_mem, wr_mem, uses_rt, dest_rd;
  logic [data_bits-1:0]  val1, val2;
  logic                  bubble;
  logic [data_bits-1:0]  regs [0:(1 << regno_bits)-1];

  assign op1    = op1_t'(fetch_inst[op1_msb:op1_lsb]);
  assign op2    = op2_t'(fetch_inst[op2_msb:op2_lsb]);
  assign imm    = fetch_inst[imm_msb:imm_lsb];
  assign rd     = fetch_inst[rd_msb:rd_lsb];
  assign rs     = fetch_inst[rs_msb:rs_lsb];
  assign rt     = fetch_inst[rt_msb:rt_lsb];
  assign imm_sx = {{(data_bits-imm_bits){imm[imm_bits-1]}}, imm};
  assign wregno = dest_rd ? rd : rt;

  always_comb begin
    wr_reg  = 1'b0;
    rd_mem  = 1'b0;
    wr_mem  = 1'b0;
    uses_rt = 1'b0;
    dest_rd = 1'b0;
    case (op1)
      op1_alur: begin
        wr_reg  = 1'b1;
        uses_rt = 1'b1;
        dest_rd = 1'b1;
      end
      op1_beq, op1_blt, op1_ble, op1_bne: uses_rt = 1'b1;
      op1_jal, op1_addi, op1_andi, op1_ori, op1_xori: wr_reg = 1'b1;
      op1_lw: begin
        wr_reg = 1'b1;
        rd_mem = 1'b1;
      end
      op1_sw: begin
        wr_mem  = 1'b1;
        uses_rt = 1'b1;  // store data
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // register file and forwarding
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wb_wr_reg && wb_wregno != '0) begin
      regs[wb_wregno] <= wb_val;
    end
  end

  // youngest producer wins and r0 always reads zero
  function automatic logic [data_bits-1:0] operand(input logic [regno_bits-1:0] regno);
    logic [data_bits-1:0] val;
    if (regno == '0) begin
      val = '0;
    end else if (dec_wr_reg && !dec_rd_mem && dec_wregno == regno) begin
      val = alu_now;
    end else if (ex_wr_reg && ex_wregno == regno) begin
      val = mem_result;
    end else if (wb_wr_reg && wb_wregno == regno) begin
      val = wb_val;
    end else begin
      val = regs[regno];
    end
    return val;
  endfunction

  always_comb begin
    val1 = operand(rs);
    val2 = operand(rt);
  end

  // load data is not ready until memory so hold one cycle
  assign stall = dec_rd_mem && dec_wregno != '0 &&
                 (dec_wregno == rs || (uses_rt && dec_wregno == rt));
  assign bubble = redirect || stall;

  // --------------------------------------------------
  // decode latch
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid  <= 1'b0;
      dec_wr_reg <= 1'b0;
      dec_rd_mem <= 1'b0;
      dec_wr_mem <= 1'b0;
    end else begin
      dec_valid  <= !bubble;
      dec_wr_reg <= wr_reg && !bubble;
      dec_rd_mem <= rd_mem && !bubble;
      dec_wr_mem <= wr_mem && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    dec_op1     <= op1;
    dec_op2     <= op2;
    dec_val1    <= val1;
    dec_val2    <= val2;
    dec_imm     <= imm_sx;
    dec_pc_next <= fetch_pc_next;
    dec_wregno  <= wregno;
  end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`default_nettype none

module execute_unit (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           dec_valid,
  input  wire cpu_pkg::op1_t                  dec_op1,
  input  wire cpu_pkg::op2_t                  dec_op2,
  input  wire logic [cpu_pkg::data_bits-1:0]  dec_val1,
  input  wire logic [cpu_pkg::data_bits-1:0]  dec_val2,
  input  wire logic [cpu_pkg::data_bits-1:0]  dec_imm,
  input  wire logic [cpu_pkg::data_bits-1:0]  dec_pc_next,
  input  wire logic [cpu_pkg::regno_bits-1:0] dec_wregno,
  input  wire logic                           dec_wr_reg,
  input  wire logic                           dec_rd_mem,
  input  wire logic                           dec_wr_mem,
  output logic                                redirect,
  output logic      [cpu_pkg::data_bits-1:0]  redirect_pc,
  output logic      [cpu_pkg::data_bits-1:0]  alu_now,
  output logic      [cpu_pkg::data_bits-1:0]  ex_alu,
  output logic      [cpu_pkg::data_bits-1:0]  ex_store_val,
  output logic      [cpu_pkg::regno_bits-1:0] ex_wregno,
  output logic                                ex_wr_reg,
  output logic                                ex_rd_mem,
  output logic                                ex_wr_mem
);

  import cpu_pkg::*;

  logic signed [data_bits-1:0] s1, s2;
  logic        [data_bits-1:0] target;
  logic                        take;

  assign s1 = dec_val1;
  assign s2 = dec_val2;

  // --------------------------------------------------
  // alu
  // --------------------------------------------------
  always_comb begin
    case (dec_op1)
      op1_alur:
        case (dec_op2)
          op2_eq:   alu_now = {{(data_bits-1){1'b0}}, s1 == s2};
          op2_lt:   alu_now = {{(data_bits-1){1'b0}}, s1 < s2};   // signed
          op2_le:   alu_now = {{(data_bits-1){1'b0}}, s1 <= s2};
          op2_ne:   alu_now = {{(data_bits-1){1'b0}}, s1 != s2};
          op2_add:  alu_now = dec_val1 + dec_val2;
          op2_and:  alu_now = dec_val1 & dec_val2;
          op2_or:   alu_now = dec_val1 | dec_val2;
          op2_xor:  alu_now = dec_val1 ^ dec_val2;
          op2_sub:  alu_now = dec_val1 - dec_val2;
          op2_nand: alu_now = ~(dec_val1 & dec_val2);
          op2_nor:  alu_now = ~(dec_val1 | dec_val2);
          op2_nxor: alu_now = ~(dec_val1 ^ dec_val2);
          op2_rshf: alu_now = s1 >>> dec_val2;                    // arithmetic
          op2_lshf: alu_now = dec_val1 << dec_val2;
          default:  alu_now = '0;
        endcase
      op1_lw, op1_sw, op1_addi: alu_now = dec_val1 + dec_imm;  // also the address
      op1_andi: alu_now = dec_val1 & dec_imm;
      op1_ori:  alu_now = dec_val1 | dec_imm;
      op1_xori: alu_now = dec_val1 ^ dec_imm;
      op1_jal:  alu_now = dec_pc_next;  // link value
      default:  alu_now = '0;
    endcase
  end

  always_comb begin
    case (dec_op1)
      op1_beq: take = s1 == s2;
      op1_blt: take = s1 < s2;
      op1_ble: take = s1 <= s2;
      op1_bne: take = s1 != s2;
      op1_jal: take = 1'b1;
      default: take = 1'b0;
    endcase
  end

  // offsets count words
  assign target = (dec_op1 == op1_jal) ? dec_val1 + (dec_imm << 2)
                                       : dec_pc_next + (dec_imm << 2);

  // --------------------------------------------------
  // execute latch
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect  <= 1'b0;
      ex_wr_reg <= 1'b0;
      ex_rd_mem <= 1'b0;
      ex_wr_mem <= 1'b0;
    end else begin
      // the slot behind a redirect is a bubble
      redirect  <= !redirect && dec_valid && take;
      ex_wr_reg <= !redirect && dec_valid && dec_wr_reg;
      ex_rd_mem <= !redirect && dec_valid && dec_rd_mem;
      ex_wr_mem <= !redirect && dec_valid && dec_wr_mem;
    end
  end

  always_ff @(posedge clk) begin
    redirect_pc  <= target;
    ex_alu       <= alu_now;
    ex_store_val <= dec_val2;
    ex_wregno    <= dec_wregno;
  end

endmodule

`default_nettype wire

//--- rtl/result_unit.sv
`default_nettype none

module result_unit (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic [cpu_pkg::data_bits-1:0]  ex_alu,
  input  wire logic [cpu_pkg::data_bits-1:0]  ex_store_val,
  input  wire logic [cpu_pkg::regno_bits-1:0] ex_wregno,
  input  wire logic                           ex_wr_reg,
  input  wire logic                           ex_rd_mem,
  input  wire logic                           ex_wr_mem,
  output logic      [cpu_pkg::data_bits-1:0]  mem_result,
  output logic      [cpu_pkg::data_bits-1:0]  wb_val,
  output logic      [cpu_pkg::regno_bits-1:0] wb_wregno,
  output logic                                wb_wr_reg,
  output logic      [cpu_pkg::led_bits-1:0]   led,
  output logic      [cpu_pkg::hex_bits-1:0]   hex
);

  import cpu_pkg::*;

  logic                      sel_led, sel_hex;
  logic [dmem_addr_bits-1:0] word_idx;
  logic [data_bits-1:0]      rd_data;
  logic [data_bits-1:0]      dmem [0:(1 << dmem_addr_bits)-1];

  assign sel_led  = ex_alu == addr_ledr;
  assign sel_hex  = ex_alu == addr_hex;
  assign word_idx = ex_alu[dmem_addr_bits+1:2];

  // --------------------------------------------------
  // data memory
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (ex_wr_mem && !sel_led && !sel_hex) begin
      dmem[word_idx] <= ex_store_val;
    end
  end

  assign rd_data    = dmem[word_idx];
  assign mem_result = ex_rd_mem ? rd_data : ex_alu;

  // output devices take stores only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      led <= '0;
      hex <= hex_reset_value;
    end else if (ex_wr_mem) begin
      if (sel_led) led <= ex_store_val[led_bits-1:0];
      if (sel_hex) hex <= ex_store_val[hex_bits-1:0];
    end
  end

  // write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_wr_reg <= 1'b0;
    end else begin
      wb_wr_reg <= ex_wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_val    <= mem_result;
    wb_wregno <= ex_wregno;
  end

endmodule

`default_nettype wire

//--- rtl/cpu_top.sv
`default_nettype none

module cpu_top (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               imem_we,
  input  wire logic [cpu_pkg::imem_addr_bits-1:0] imem_addr,
  input  wire logic [cpu_pkg::data_bits-1:0]      imem_data,
  output logic      [cpu_pkg::led_bits-1:0]       led,
  output logic      [cpu_pkg::hex_bits-1:0]       hex
);

  import cpu_pkg::*;

  // fetch to decode
  logic [data_bits-1:0]  fetch_inst, fetch_pc_next;
  logic                  stall;

  // decode latch
  logic                  dec_valid;
  op1_t                  dec_op1;
  op2_t                  dec_op2;
  logic [data_bits-1:0]  dec_val1, dec_val2, dec_imm, dec_pc_next;
  logic [regno_bits-1:0] dec_wregno;
  logic                  dec_wr_reg, dec_rd_mem, dec_wr_mem;

  // execute latch and redirect
  logic                  redirect;
  logic [data_bits-1:0]  redirect_pc, alu_now, ex_alu, ex_store_val;
  logic [regno_bits-1:0] ex_wregno;
  logic                  ex_wr_reg, ex_rd_mem, ex_wr_mem;

  // memory and write-back
  logic [data_bits-1:0]  mem_result, wb_val;
  logic [regno_bits-1:0] wb_wregno;
  logic                  wb_wr_reg;

  fetch_unit fetch_unit_inst (
    .clk, .reset, .stall, .redirect, .redirect_pc,
    .imem_we, .imem_addr, .imem_data,
    .fetch_inst, .fetch_pc_next
  );

  decode_unit decode_unit_inst (
    .clk, .reset, .fetch_inst, .fetch_pc_next, .redirect,
    .alu_now, .ex_wregno, .ex_wr_reg,
    .mem_result, .wb_val, .wb_wregno, .wb_wr_reg,
    .stall, .dec_valid, .dec_op1, .dec_op2,
    .dec_val1, .dec_val2, .dec_imm, .dec_pc_next,
    .dec_wregno, .dec_wr_reg, .dec_rd_mem, .dec_wr_mem
  );

  execute_unit execute_unit_inst (
    .clk, .reset, .dec_valid, .dec_op1, .dec_op2,
    .dec_val1, .dec_val2, .dec_imm, .dec_pc_next,
    .dec_wregno, .dec_wr_reg, .dec_rd_mem, .dec_wr_mem,
    .redirect, .redirect_pc, .alu_now, .ex_alu, .ex_store_val,
    .ex_wregno, .ex_wr_reg, .ex_rd_mem, .ex_wr_mem
  );

  result_unit result_unit_inst (
    .clk, .reset, .ex_alu, .ex_store_val,
    .ex_wregno, .ex_wr_reg, .ex_rd_mem, .ex_wr_mem,
    .mem_result, .wb_val, .wb_wregno, .wb_wr_reg,
    .led, .hex
  );

endmodule

`default_nettype wire

//--- testbench/cpu_programs.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// --------------------------------------------------
// instruction encoding
// --------------------------------------------------
function automatic logic [data_bits-1:0] encode_reg_op(op2_t f, int rd, int rs, int rt);
  return {op1_alur, f, 6'b000000, 4'(rd), 4'(rs), 4'(rt)};
endfunction

// i-type with rt as the destination or the second source
function automatic logic [data_bits-1:0] encode_imm_op(op1_t op, logic [imm_bits-1:0] imm,
                                                       int rs, int rt);
  return {op, 2'b00, imm, 4'(rs), 4'(rt)};
endfunction

function automatic logic [data_bits-1:0] addi_word(int rt, int rs, logic [imm_bits-1:0] imm);
  return encode_imm_op(op1_addi, imm, rs, rt);
endfunction

function automatic logic [data_bits-1:0] sw_word(int rt, int rs, logic [imm_bits-1:0] imm);
  return encode_imm_op(op1_sw, imm, rs, rt);  // stores rt at rs + imm
endfunction

function automatic logic [data_bits-1:0] lw_word(int rt, int rs, logic [imm_bits-1:0] imm);
  return encode_imm_op(op1_lw, imm, rs, rt);
endfunction

// offset counts words from the following instruction
function automatic logic [data_bits-1:0] branch_word(op1_t op, int rs, int rt,
                                                     logic [imm_bits-1:0] off);
  return encode_imm_op(op, off, rs, rt);
endfunction

function automatic logic [data_bits-1:0] jal_word(int rt, int rs, logic [imm_bits-1:0] imm);
  return encode_imm_op(op1_jal, imm, rs, rt);
endfunction

// --------------------------------------------------
// program images
// --------------------------------------------------
// device addresses fit a sign-extended offset from r0
task automatic push_hex_store(int rt);
  prog.push_back(sw_word(rt, 0, addr_hex[imm_bits-1:0]));
endtask

task automatic push_done_and_spin();
  prog.push_back(addi_word(15, 0, {6'b000000, done_marker}));
  prog.push_back(sw_word(15, 0, addr_ledr[imm_bits-1:0]));
  prog.push_back(branch_word(op1_beq, 0, 0, 16'hFFFF));  // branch to itself
endtask

task automatic build_alu_reg(op2_t f, logic [imm_bits-1:0] a, logic [imm_bits-1:0] b);
  prog.delete();
  prog.push_back(addi_word(1, 0, a));
  prog.push_back(addi_word(2, 0, b));
  prog.push_back(encode_reg_op(f, 3, 1, 2));
  push_hex_store(3);
  push_done_and_spin();
endtask

task automatic build_alu_imm(op1_t op, logic [imm_bits-1:0] a, logic [imm_bits-1:0] imm);
  prog.delete();
  prog.push_back(addi_word(1, 0, a));
  prog.push_back(encode_imm_op(op, imm, 1, 3));
  push_hex_store(3);
  push_done_and_spin();
endtask

// every add reads the result of the one just before it
task automatic build_add_chain(logic [imm_bits-1:0] a, logic [imm_bits-1:0] b);
  prog.delete();
  prog.push_back(addi_word(1, 0, a));
  prog.push_back(addi_word(2, 0, b));
  prog.push_back(encode_reg_op(op2_add, 3, 1, 2));
  prog.push_back(encode_reg_op(op2_add, 4, 3, 1));
  prog.push_back(encode_reg_op(op2_add, 5, 4, 3));
  prog.push_back(encode_reg_op(op2_add, 6, 5, 4));
  prog.push_back(encode_reg_op(op2_add, 7, 6, 5));
  push_hex_store(7);
  push_done_and_spin();
endtask

task automatic build_load_use(logic [imm_bits-1:0] val, logic [imm_bits-1:0] k);
  prog.delete();
  prog.push_back(addi_word(1, 0, val));
  prog.push_back(sw_word(1, 0, 16'h0040));
  prog.push_back(lw_word(2, 0, 16'h0040));
  prog.push_back(addi_word(3, 2, k));  // needs the loaded word at once
  push_hex_store(3);
  push_done_and_spin();
endtask

task automatic build_count_loop(logic [imm_bits-1:0] n);
  prog.delete();
  prog.push_back(addi_word(1, 0, 16'h0000));
  prog.push_back(addi_word(2, 0, n));
  prog.push_back(addi_word(1, 1, 16'h0001));
  prog.push_back(branch_word(op1_blt, 1, 2, 16'hFFFE));  // back to the increment
  push_hex_store(1);
  push_done_and_spin();
endtask

task automatic build_beq_skip(logic [imm_bits-1:0] good, logic [imm_bits-1:0] bad);
  prog.delete();
  prog.push_back(addi_word(1, 0, good));
  prog.push_back(addi_word(2, 0, bad));
  push_hex_store(1);
  prog.push_back(branch_word(op1_beq, 1, 1, 16'h0001));
  push_hex_store(2);  // jumped over
  push_done_and_spin();
endtask

task automatic build_bne_fall(logic [imm_bits-1:0] v, logic [imm_bits-1:0] mark);
  prog.delete();
  prog.push_back(addi_word(1, 0, v));
  prog.push_back(addi_word(2, 0, v));
  prog.push_back(branch_word(op1_bne, 1, 2, 16'h0002));
  prog.push_back(addi_word(3, 0, mark));
  push_hex_store(3);
  push_done_and_spin();
endtask

// routine sits four words past the jal
task automatic build_jal_call(logic [imm_bits-1:0] bad, output logic [data_bits-1:0] jal_addr);
  int jal_index;
  prog.delete();
  prog.push_back(addi_word(1, 0, 16'h0011));
  jal_index = prog.size();
  jal_addr  = start_pc + data_bits'(4 * jal_index);
  prog.push_back(jal_word(5, 0, imm_bits'((start_pc >> 2) + data_bits'(jal_index + 4))));
  prog.push_back(addi_word(6, 0, bad));
  push_hex_store(6);
  prog.push_back(branch_word(op1_beq, 0, 0, 16'hFFFF));
  push_hex_store(5);  // link register
  push_done_and_spin();
endtask

`endif

//--- testbench/cpu_tb.sv
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cpu_pkg::*;

  localparam int clk_period   = 20;
  localparam int drive_delay  = 2;
  localparam int reset_cycles = 8;
  localparam int done_wait    = 300;
  localparam int max_cycles   = 2000;  // six tests of 300 cycles plus margin
  localparam logic [led_bits-1:0] done_marker     = 10'h3FF;
  localparam logic [hex_bits-1:0] hex_after_reset = 24'hFEDEAD;

  logic                      clk;
  logic                      reset;
  logic                      imem_we;
  logic [imem_addr_bits-1:0] imem_addr;
  logic [data_bits-1:0]      imem_data;
  logic [led_bits-1:0]       led;
  logic [hex_bits-1:0]       hex;

  logic [data_bits-1:0] prog [$];  // image of the next program
  int cycles       = 0;
  int test_errors  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  `include "cpu_programs.svh"

  cpu_top cpu_top_inst (
    .clk, .reset, .imem_we, .imem_addr, .imem_data, .led, .hex
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("run stopped at cycle %0d, the tests did not finish in time", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [data_bits-1:0] sign_extend(logic [imm_bits-1:0] v);
    return {{(data_bits - imm_bits){v[imm_bits-1]}}, v};
  endfunction

  function automatic logic [data_bits-1:0] model_alur(op2_t f, logic [data_bits-1:0] a,
                                                     logic [data_bits-1:0] b);
    logic [data_bits-1:0] r;
    case (f)
      op2_eq:   r = (a == b) ? 32'd1 : 32'd0;
      op2_lt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op2_le:   r = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      op2_ne:   r = (a != b) ? 32'd1 : 32'd0;
      op2_add:  r = a + b;
      op2_and:  r = a & b;
      op2_or:   r = a | b;
      op2_xor:  r = a ^ b;
      op2_sub:  r = a - b;
      op2_nand: r = ~(a & b);
      op2_nor:  r = ~(a | b);
      op2_nxor: r = a ~^ b;
      op2_rshf: r = $signed(a) >>> b;  // sign fill
      op2_lshf: r = a << b;
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [data_bits-1:0] model_alui(op1_t op, logic [data_bits-1:0] a,
                                                     logic [imm_bits-1:0] imm);
    logic [data_bits-1:0] r;
    case (op)
      op1_andi: r = a & sign_extend(imm);
      op1_ori:  r = a | sign_extend(imm);
      op1_xori: r = a ^ sign_extend(imm);
      default:  r = '0;
    endcase
    return r;
  endfunction

  // --------------------------------------------------
  // drivers and checks
  // --------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #drive_delay;
  endtask

  // writes the image while reset is held and then releases reset
  task automatic load_program();
    int i;
    reset = 1'b1;
    for (i = 0; i < prog.size(); i++) begin
      imem_we   = 1'b1;
      imem_addr = imem_addr_bits'((start_pc >> 2) + data_bits'(i));
      imem_data = prog[i];
      tick();
    end
    imem_we = 1'b0;
    for (i = prog.size(); i < reset_cycles; i++) begin
      tick();
    end
    reset = 1'b0;
  endtask

  task automatic run_and_check(string name, logic [data_bits-1:0] expected);
    bit done;
    int n;
    done = 1'b0;
    load_program();
    for (n = 0; n < done_wait && !done; n++) begin
      tick();
      if (led == done_marker) done = 1'b1;
    end
    assert (done) else begin
      $display("%s: the program never wrote the done marker to led in %0d cycles",
               name, done_wait);
      test_errors++;
    end
    if (done) begin
      assert (hex == expected[hex_bits-1:0]) else begin
        $display("FAILED at %0d ns: hex = %h, expected %h (%s)",
                 $time, hex, expected[hex_bits-1:0], name);
        test_errors++;
      end
    end
  endtask

  task automatic report_test(string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, test_errors);
    end
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_reset_state();
    int i;
    reset = 1'b1;
    for (i = 0; i < reset_cycles; i++) begin
      tick();
    end
    assert (led == '0) else begin
      $display("FAILED at %0d ns: led = %h, expected %h", $time, led, 10'h000);
      test_errors++;
    end
    assert (hex == hex_after_reset) else begin
      $display("FAILED at %0d ns: hex = %h, expected %h", $time, hex, hex_after_reset);
      test_errors++;
    end
    report_test("reset state");
  endtask

  task automatic test_alu();
    op1_t                imm_ops [3] = '{op1_andi, op1_ori, op1_xori};
    op1_t                op;
    op2_t                f;
    logic [imm_bits-1:0] a;
    logic [imm_bits-1:0] b;
    int                  k;
    a = 16'h8421;  // negative once extended
    f = f.first();
    for (k = 0; k < f.num(); k++) begin
      b = (f == op2_rshf || f == op2_lshf) ? 16'h0005 : 16'h0F0F;
      build_alu_reg(f, a, b);
      run_and_check({"alu ", f.name()}, model_alur(f, sign_extend(a), sign_extend(b)));
      f = f.next();
    end
    for (k = 0; k < 3; k++) begin
      op = imm_ops[k];
      build_alu_imm(op, a, 16'hF0F0);
      run_and_check({"alu ", op.name()}, model_alui(op, sign_extend(a), 16'hF0F0));
    end
    report_test("alu");
  endtask

  task automatic test_forwarding();
    logic [data_bits-1:0] a;
    logic [data_bits-1:0] b;
    logic [data_bits-1:0] r3, r4, r5, r6, r7;
    a  = sign_extend(16'h0123);
    b  = sign_extend(16'h0456);
    r3 = a + b;
    r4 = r3 + a;
    r5 = r4 + r3;
    r6 = r5 + r4;
    r7 = r6 + r5;
    build_add_chain(16'h0123, 16'h0456);
    run_and_check("add chain", r7);
    report_test("forwarding");
  endtask

  task automatic test_load_use();
    build_load_use(16'h02A5, 16'h0100);
    run_and_check("load use", sign_extend(16'h02A5) + sign_extend(16'h0100));
    report_test("load-use");
  endtask

  task automatic test_branches();
    build_count_loop(16'h0006);
    run_and_check("blt loop", 32'd6);
    build_beq_skip(16'h00AB, 16'h0BAD);
    run_and_check("beq taken", 32'h0000_00AB);
    build_bne_fall(16'h0005, 16'h00C3);
    run_and_check("bne not taken", 32'h0000_00C3);
    report_test("branches");
  endtask

  task automatic test_jal();
    logic [data_bits-1:0] jal_addr;
    build_jal_call(16'h0BAD, jal_addr);
    run_and_check("jal link", jal_addr + 32'd4);
    report_test("jal");
  endtask

  initial begin
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_reset_state();
    test_alu();
    test_forwarding();
    test_load_use();
    test_branches();
    test_jal();
    $display("summary: %0d test(s) passed, %0d test(s) failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/cpu_top.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
